//--- compile.f
+incdir+include
source/serdes_rx_pkg.sv
source/crc16_d16.sv
source/serdes_rx_deframer.sv
source/serdes_rx_fifo.sv
source/serdes_rx_buf_if.sv
source/serdes_rx_link_mon.sv
source/serdes_rx.sv
testbench/tb_serdes_rx.sv

//--- testbench/tb_serdes_rx.sv
`timescale 1ns/1ps
`include "serdes_rx_config.svh"

module tb_serdes_rx;

   logic        ser_rx_clk;
   logic        rst_rxclk;
   logic [15:0] ser_r_i;
   logic        ser_rklsb_i;
   logic        ser_rkmsb_i;
   logic [31:0] wr_dat_o;
   logic        wr_write_o;
   logic        wr_done_o;
   logic        wr_error_o;
   logic        wr_ready_i;
   logic        wr_full_i;
   logic [15:0] fifo_space_o;
   logic [15:0] fifo_occupied_o;
   logic        fifo_full_o;
   logic        fifo_empty_o;
   logic        xon_rcvd_o;
   logic        xoff_rcvd_o;
   logic        link_up_o;

   logic [31:0] lfsr_q;
   logic [8:0]  tx_bytes[$];  // {k, byte}, LS byte of each word first
   logic [33:0] exp_q[$];     // {error, done, line}
   logic [33:0] exp_line;
   int          write_count;
   int          nlines;
   int          writes_before;

   serdes_rx u_dut
   (
      .ser_rx_clk      (ser_rx_clk),
      .rst_rxclk       (rst_rxclk),
      .ser_r_i         (ser_r_i),
      .ser_rklsb_i     (ser_rklsb_i),
      .ser_rkmsb_i     (ser_rkmsb_i),
      .wr_dat_o        (wr_dat_o),
      .wr_write_o      (wr_write_o),
      .wr_done_o       (wr_done_o),
      .wr_error_o      (wr_error_o),
      .wr_ready_i      (wr_ready_i),
      .wr_full_i       (wr_full_i),
      .fifo_space_o    (fifo_space_o),
      .fifo_occupied_o (fifo_occupied_o),
      .fifo_full_o     (fifo_full_o),
      .fifo_empty_o    (fifo_empty_o),
      .xon_rcvd_o      (xon_rcvd_o),
      .xoff_rcvd_o     (xoff_rcvd_o),
      .link_up_o       (link_up_o)
   );

   always #2 ser_rx_clk = ~ser_rx_clk;

   task automatic fail_stop(input string what);
      $display("%s", what);
      $display("TEST FAIL");
      $fatal(1, "Simulation stopped on first error");
   endtask

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_q = lfsr_next(lfsr_q);
         v      = {v[30:0], lfsr_q[0]};  // One step per bit
      end
      return v;
   endfunction

   // CRC-16 0x1021, one word, MSB first
   function automatic logic [15:0] crc16_ref(input logic [15:0] crc, input logic [15:0] d);
      logic [15:0] c;
      c = crc;
      for (int i = 15; i >= 0; i--)
      begin
         if (c[15] ^ d[i])
            c = (c << 1) ^ 16'h1021;
         else
            c = c << 1;
      end
      return c;
   endfunction

   task automatic push_byte(input logic k, input logic [7:0] b);
      tx_bytes.push_back({k, b});
   endtask

   task automatic push_comma();
      push_byte(1'b0, `SERDES_RX_D_56);
      push_byte(1'b1, `SERDES_RX_K_COMMA);
   endtask

   task automatic push_data(input logic [15:0] w);
      push_byte(1'b0, w[7:0]);
      push_byte(1'b0, w[15:8]);
   endtask

   task automatic push_filler();
      logic [1:0] sel;
      sel = rand_bits(2);
      case (sel)
         2'd1: push_comma();
         2'd2:
         begin
            push_byte(1'b1, `SERDES_RX_K_XON);
            push_byte(1'b1, `SERDES_RX_K_XON);
         end
         2'd3:
         begin
            push_byte(1'b1, `SERDES_RX_K_XOFF);
            push_byte(1'b1, `SERDES_RX_K_XOFF);
         end
         default: ;  // No filler this time
      endcase
   endtask

   // Queues one packet's bytes and its expected lines
   task automatic build_packet(input int n, input bit odd, input bit fill, input bit bad);
      logic [15:0] crc;
      logic [15:0] lo;
      logic [15:0] hi;
      logic [15:0] trailer;
      bit          last;
      crc = 16'hFFFF;
      if (odd)
         push_byte(1'b0, `SERDES_RX_D_56);  // One byte shift
      repeat (4) push_comma();
      push_byte(1'b1, `SERDES_RX_K_PKT_START);
      push_byte(1'b1, `SERDES_RX_K_PKT_START);
      for (int i = 0; i < n; i++)
      begin
         lo   = rand_bits(16);
         hi   = rand_bits(16);
         last = (i == n - 1);
         if (fill)
            push_filler();
         push_data(lo);
         if (fill)
            push_filler();
         push_data(hi);
         crc = crc16_ref(crc16_ref(crc, lo), hi);
         exp_q.push_back({bad && last, !bad && last, hi, lo});
      end
      trailer = bad ? (crc ^ (16'h0001 << rand_bits(4))) : crc;
      if (fill)
         push_filler();
      push_data(trailer);
      push_byte(1'b1, `SERDES_RX_K_PKT_END);
      push_byte(1'b1, `SERDES_RX_K_PKT_END);
      if (odd)
         push_byte(1'b1, `SERDES_RX_K_COMMA);  // Back to word alignment
      repeat (2) push_comma();
   endtask

   task automatic drive_word(input logic kmsb, input logic klsb, input logic [15:0] r);
      ser_r_i     = r;
      ser_rklsb_i = klsb;
      ser_rkmsb_i = kmsb;
   endtask

   task automatic drive_comma();
      drive_word(1'b1, 1'b0, {`SERDES_RX_K_COMMA, `SERDES_RX_D_56});
   endtask

   task automatic send_stream();
      logic [8:0] b0;
      logic [8:0] b1;
      while (tx_bytes.size() >= 2)
      begin
         b0 = tx_bytes.pop_front();
         b1 = tx_bytes.pop_front();
         @(negedge ser_rx_clk);
         drive_word(b1[8], b0[8], {b1[7:0], b0[7:0]});
      end
   endtask

   task automatic wait_drain(input int limit);
      int n;
      n = 0;
      while (!((exp_q.size() == 0) && fifo_empty_o) && (n < limit))
      begin
         @(negedge ser_rx_clk);
         n++;
      end
      assert ((exp_q.size() == 0) && fifo_empty_o)
      else
         fail_stop("Timeout: expected lines were not all delivered to the writer");
   endtask

   task automatic wait_fifo_level(input int count, input int limit);
      int n;
      n = 0;
      while ((fifo_occupied_o != count) && (n < limit))
      begin
         @(negedge ser_rx_clk);
         n++;
      end
      assert (fifo_occupied_o == count)
      else
         fail_stop($sformatf("Timeout: fifo_occupied_o stayed at 0x%h instead of 0x%h",
                             fifo_occupied_o, count));
   endtask

   task automatic wait_link(input logic level, input int limit, input string what);
      int n;
      n = 0;
      while ((link_up_o != level) && (n < limit))
      begin
         @(negedge ser_rx_clk);
         n++;
      end
      assert (link_up_o == level) else fail_stop(what);
   endtask

   // One registered pulse, then quiet again
   task automatic check_flow_word(input logic kmsb, input logic klsb, input logic [15:0] r,
                                  input logic exp_xon, input logic exp_xoff);
      @(negedge ser_rx_clk);
      drive_word(kmsb, klsb, r);
      @(negedge ser_rx_clk);
      drive_comma();
      assert (xon_rcvd_o == exp_xon)
      else
         fail_stop($sformatf("MISMATCH xon_rcvd_o got 0x%h expected 0x%h", xon_rcvd_o, exp_xon));
      assert (xoff_rcvd_o == exp_xoff)
      else
         fail_stop($sformatf("MISMATCH xoff_rcvd_o got 0x%h expected 0x%h",
                             xoff_rcvd_o, exp_xoff));
      @(negedge ser_rx_clk);
      assert (!xon_rcvd_o && !xoff_rcvd_o)
      else
         fail_stop("Flow-control pulse lasted longer than one cycle");
   endtask

   // Scoreboard compare on every writer strobe
   always @(posedge ser_rx_clk)
   begin
      if (!rst_rxclk && wr_write_o)
      begin
         write_count++;
         assert (exp_q.size() > 0)
         else
            fail_stop($sformatf("Writer strobe with line 0x%h but no line expected", wr_dat_o));
         exp_line = exp_q.pop_front();
         assert (wr_dat_o == exp_line[31:0])
         else
            fail_stop($sformatf("MISMATCH wr_dat_o got 0x%h expected 0x%h",
                                wr_dat_o, exp_line[31:0]));
         assert (wr_done_o == exp_line[32])
         else
            fail_stop($sformatf("MISMATCH wr_done_o got 0x%h expected 0x%h",
                                wr_done_o, exp_line[32]));
         assert (wr_error_o == exp_line[33])
         else
            fail_stop($sformatf("MISMATCH wr_error_o got 0x%h expected 0x%h",
                                wr_error_o, exp_line[33]));
      end
   end

   initial
   begin
      ser_rx_clk  = 1'b0;
      rst_rxclk   = 1'b1;
      wr_ready_i  = 1'b1;
      wr_full_i   = 1'b0;
      lfsr_q      = 32'ha01e08cf;
      write_count = 0;
      drive_comma();
      repeat (5) @(posedge ser_rx_clk);
      @(negedge ser_rx_clk);
      assert (!wr_write_o && !wr_done_o && !wr_error_o && fifo_empty_o && !fifo_full_o)
      else
         fail_stop("Writer outputs or FIFO flags wrong during reset");
      assert (!xon_rcvd_o && !xoff_rcvd_o && !link_up_o)
      else
         fail_stop("Link monitor outputs not low during reset");
      rst_rxclk = 1'b0;
      wait_link(1'b1, 10, "Timeout: link_up_o never rose after reset");

      // Even phase, clean stream
      build_packet(1 + rand_bits(3), 1'b0, 1'b0, 1'b0);
      send_stream();
      wait_drain(200);

      // Odd phase with filler words
      build_packet(1 + rand_bits(3), 1'b1, 1'b1, 1'b0);
      send_stream();
      wait_drain(300);

      // Bad trailer, then a good packet right behind it
      build_packet(2 + rand_bits(3), 1'b0, 1'b0, 1'b1);
      build_packet(1 + rand_bits(3), 1'b1, 1'b0, 1'b0);
      send_stream();
      wait_drain(300);

      check_flow_word(1'b0, 1'b1, {8'h12, `SERDES_RX_K_XON}, 1'b1, 1'b0);
      check_flow_word(1'b1, 1'b0, {`SERDES_RX_K_XON, 8'h34}, 1'b1, 1'b0);
      check_flow_word(1'b0, 1'b1, {8'h56, `SERDES_RX_K_XOFF}, 1'b0, 1'b1);
      check_flow_word(1'b1, 1'b0, {`SERDES_RX_K_XOFF, 8'h78}, 1'b0, 1'b1);
      check_flow_word(1'b0, 1'b0, {`SERDES_RX_K_XON, `SERDES_RX_K_XOFF}, 1'b0, 1'b0);

      // Loss of signal drops the link
      @(negedge ser_rx_clk);
      drive_word(1'b1, 1'b1, {`SERDES_RX_K_LOS, `SERDES_RX_K_LOS});
      @(negedge ser_rx_clk);
      drive_comma();
      wait_link(1'b0, 4, "link_up_o did not fall after a loss-of-signal word");
      wait_link(1'b1, 4, "link_up_o did not return after good words");

      // Writer not ready, lines pile up in the FIFO
      @(negedge ser_rx_clk);
      wr_ready_i    = 1'b0;
      writes_before = write_count;
      nlines        = 4 + rand_bits(3);
      build_packet(nlines, 1'b0, 1'b1, 1'b0);
      send_stream();
      wait_fifo_level(nlines, 20);
      assert (fifo_space_o == ((1 << `SERDES_RX_FIFO_AWIDTH) - 1) - nlines)
      else
         fail_stop($sformatf("MISMATCH fifo_space_o got 0x%h expected 0x%h", fifo_space_o,
                             ((1 << `SERDES_RX_FIFO_AWIDTH) - 1) - nlines));
      assert (!fifo_full_o)
      else
         fail_stop($sformatf("MISMATCH fifo_full_o got 0x%h expected 0x%h", fifo_full_o, 1'b0));
      assert (write_count == writes_before)
      else
         fail_stop("Writer strobe seen while wr_ready_i was low");
      wr_ready_i = 1'b1;
      wait_drain(200);

      // A few back to back packets of mixed phase
      repeat (4)
         build_packet(1 + rand_bits(3), rand_bits(1), rand_bits(1), 1'b0);
      send_stream();
      wait_drain(1000);

      if (exp_q.size() == 0)
      begin
         $display("TEST PASS");
         $finish;
      end
      else
         fail_stop("Expected lines left over at the end of the run");
   end

endmodule

//--- source/serdes_rx.sv
`timescale 1ns/1ps
`include "serdes_rx_config.svh"

module serdes_rx
(
   input  logic        ser_rx_clk,
   input  logic        rst_rxclk,
   input  logic [15:0] ser_r_i,
   input  logic        ser_rklsb_i,
   input  logic        ser_rkmsb_i,
   output logic [31:0] wr_dat_o,
   output logic        wr_write_o,
   output logic        wr_done_o,
   output logic        wr_error_o,
   input  logic        wr_ready_i,
   input  logic        wr_full_i,
   output logic [15:0] fifo_space_o,
   output logic [15:0] fifo_occupied_o,
   output logic        fifo_full_o,
   output logic        fifo_empty_o,
   output logic        xon_rcvd_o,
   output logic        xoff_rcvd_o,
   output logic        link_up_o
);

   localparam int AWIDTH = `SERDES_RX_FIFO_AWIDTH;

   serdes_rx_pkg::rx_entry_t wr_entry;
   serdes_rx_pkg::rx_entry_t head_entry;
   logic                     entry_write;
   logic                     fifo_read;
   logic                     fifo_full;
   logic                     fifo_empty;
   logic [AWIDTH-1:0]        fifo_level;

   serdes_rx_deframer u_deframer
   (
      .ser_rx_clk    (ser_rx_clk),
      .rst_rxclk     (rst_rxclk),
      .ser_r_i       (ser_r_i),
      .ser_rklsb_i   (ser_rklsb_i),
      .ser_rkmsb_i   (ser_rkmsb_i),
      .fifo_full_i   (fifo_full),
      .entry_o       (wr_entry),
      .entry_write_o (entry_write)
   );

   serdes_rx_fifo #(.AWIDTH(AWIDTH)) u_fifo
   (
      .ser_rx_clk (ser_rx_clk),
      .rst_rxclk  (rst_rxclk),
      .wr_entry_i (wr_entry),
      .write_i    (entry_write),
      .full_o     (fifo_full),
      .rd_entry_o (head_entry),
      .read_i     (fifo_read),
      .empty_o    (fifo_empty),
      .level_o    (fifo_level)
   );

   serdes_rx_buf_if u_buf_if
   (
      .ser_rx_clk (ser_rx_clk),
      .rst_rxclk  (rst_rxclk),
      .head_i     (head_entry),
      .empty_i    (fifo_empty),
      .read_o     (fifo_read),
      .wr_dat_o   (wr_dat_o),
      .wr_write_o (wr_write_o),
      .wr_done_o  (wr_done_o),
      .wr_error_o (wr_error_o),
      .wr_ready_i (wr_ready_i),
      .wr_full_i  (wr_full_i)
   );

   serdes_rx_link_mon u_link_mon
   (
      .ser_rx_clk  (ser_rx_clk),
      .rst_rxclk   (rst_rxclk),
      .ser_r_i     (ser_r_i),
      .ser_rklsb_i (ser_rklsb_i),
      .ser_rkmsb_i (ser_rkmsb_i),
      .xon_rcvd_o  (xon_rcvd_o),
      .xoff_rcvd_o (xoff_rcvd_o),
      .link_up_o   (link_up_o)
   );

   // Usable depth is 2^AWIDTH - 1
   assign fifo_occupied_o = {{(16-AWIDTH){1'b0}}, fifo_level};
   assign fifo_space_o    = {{(16-AWIDTH){1'b0}}, {AWIDTH{1'b1}}} - fifo_occupied_o;
   assign fifo_full_o     = fifo_full;
   assign fifo_empty_o    = fifo_empty;

endmodule

//--- source/serdes_rx_link_mon.sv
`timescale 1ns/1ps
`include "serdes_rx_config.svh"

module serdes_rx_link_mon
(
   input  logic        ser_rx_clk,
   input  logic        rst_rxclk,
   input  logic [15:0] ser_r_i,
   input  logic        ser_rklsb_i,
   input  logic        ser_rkmsb_i,
   output logic        xon_rcvd_o,
   output logic        xoff_rcvd_o,
   output logic        link_up_o
);

   localparam logic [17:0] W_ERROR = {2'b11, `SERDES_RX_K_ERROR, `SERDES_RX_K_ERROR};
   localparam logic [17:0] W_LOS   = {2'b11, `SERDES_RX_K_LOS, `SERDES_RX_K_LOS};

   logic [17:0] word;
   logic        xon_hit;
   logic        xoff_hit;
   logic        sample_good;
   logic [3:0]  hist_q;   // Newest sample in bit 0

   assign word = {ser_rkmsb_i, ser_rklsb_i, ser_r_i};

   // Either lane counts
   assign xon_hit  = ({ser_rkmsb_i, ser_r_i[15:8]} == {1'b1, `SERDES_RX_K_XON}) ||
                     ({ser_rklsb_i, ser_r_i[7:0]} == {1'b1, `SERDES_RX_K_XON});
   assign xoff_hit = ({ser_rkmsb_i, ser_r_i[15:8]} == {1'b1, `SERDES_RX_K_XOFF}) ||
                     ({ser_rklsb_i, ser_r_i[7:0]} == {1'b1, `SERDES_RX_K_XOFF});

   assign sample_good = (word != W_ERROR) && (word != W_LOS);

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
      begin
         xon_rcvd_o  <= 1'b0;
         xoff_rcvd_o <= 1'b0;
         hist_q      <= 4'd0;
         link_up_o   <= 1'b0;
      end
      else
      begin
         xon_rcvd_o  <= xon_hit;
         xoff_rcvd_o <= xoff_hit;
         hist_q      <= {hist_q[2:0], sample_good};
         link_up_o   <= &hist_q[`SERDES_RX_LINK_FILTER-1:0];  // All recent samples clean
      end
   end

endmodule

//--- source/serdes_rx_buf_if.sv
`timescale 1ns/1ps

module serdes_rx_buf_if
(
   input  logic                     ser_rx_clk,
   input  logic                     rst_rxclk,
   input  serdes_rx_pkg::rx_entry_t head_i,
   input  logic                     empty_i,
   output logic                     read_o,
   output logic [31:0]              wr_dat_o,
   output logic                     wr_write_o,
   output logic                     wr_done_o,
   output logic                     wr_error_o,
   input  logic                     wr_ready_i,
   input  logic                     wr_full_i
);

   logic active_q;  // A packet is going to the writer

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
         active_q <= 1'b0;
      else if (active_q && (wr_full_i || (!empty_i && (head_i.eop || head_i.err))))
         active_q <= 1'b0;   // Packet finished or writer aborted
      else if (!active_q && !empty_i && wr_ready_i && head_i.sop)
         active_q <= 1'b1;
   end

   // Lines without a start flag seen while idle are leftovers, drop them
   assign read_o = (active_q | ~head_i.sop) & ~empty_i;

   assign wr_write_o = active_q & ~empty_i;
   assign wr_done_o  = wr_write_o & head_i.eop;
   assign wr_error_o = wr_write_o & head_i.err;
   assign wr_dat_o   = head_i.line;

endmodule

//--- source/serdes_rx_fifo.sv
`timescale 1ns/1ps
`include "serdes_rx_config.svh"

module serdes_rx_fifo
#(
   parameter int AWIDTH = `SERDES_RX_FIFO_AWIDTH
)
(
   input  logic                     ser_rx_clk,
   input  logic                     rst_rxclk,
   input  serdes_rx_pkg::rx_entry_t wr_entry_i,
   input  logic                     write_i,
   output logic                     full_o,
   output serdes_rx_pkg::rx_entry_t rd_entry_o,
   input  logic                     read_i,
   output logic                     empty_o,
   output logic [AWIDTH-1:0]        level_o
);

   localparam int DEPTH = 1 << AWIDTH;

   serdes_rx_pkg::rx_entry_t mem [DEPTH];
   logic [AWIDTH-1:0]        wr_ptr_q;
   logic [AWIDTH-1:0]        rd_ptr_q;
   logic                     push;
   logic                     pop;

   assign push = write_i & ~full_o;   // Writes while full are dropped
   assign pop  = read_i & ~empty_o;

   always_ff @(posedge ser_rx_clk)
   begin
      if (push)
         mem[wr_ptr_q] <= wr_entry_i;
   end

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
      end
   end

   // One slot stays free so full and empty differ
   assign level_o = wr_ptr_q - rd_ptr_q;
   assign full_o  = &level_o;
   assign empty_o = (wr_ptr_q == rd_ptr_q);

   assign rd_entry_o = mem[rd_ptr_q];  // Head visible the cycle after its push

endmodule

//--- source/serdes_rx_deframer.sv
`timescale 1ns/1ps
`include "serdes_rx_config.svh"

module serdes_rx_deframer
(
   input  logic                     ser_rx_clk,
   input  logic                     rst_rxclk,
   input  logic [15:0]              ser_r_i,
   input  logic                     ser_rklsb_i,
   input  logic                     ser_rkmsb_i,
   input  logic                     fifo_full_i,
   output serdes_rx_pkg::rx_entry_t entry_o,
   output logic                     entry_write_o
);

   // Word patterns as {k_msb, k_lsb, msb, lsb}
   localparam logic [17:0] W_START =
      {2'b11, `SERDES_RX_K_PKT_START, `SERDES_RX_K_PKT_START};
   localparam logic [17:0] W_END   = {2'b11, `SERDES_RX_K_PKT_END, `SERDES_RX_K_PKT_END};
   localparam logic [17:0] W_COMMA = {2'b10, `SERDES_RX_K_COMMA, `SERDES_RX_D_56};
   localparam logic [17:0] W_XON   = {2'b11, `SERDES_RX_K_XON, `SERDES_RX_K_XON};
   localparam logic [17:0] W_XOFF  = {2'b11, `SERDES_RX_K_XOFF, `SERDES_RX_K_XOFF};

   logic [17:0]               even_word;
   logic [17:0]               odd_word;
   logic [17:0]               word;
   logic [8:0]                holder_q;   // Previous MS byte and its K flag
   logic                      odd_q;
   serdes_rx_pkg::rx_state_t  state_q;
   logic [15:0]               last_q;     // Most recent data word
   logic [31:0]               line_q;     // Line waiting for its push
   logic                      sop_q;
   logic [15:0]               crc_q;
   logic [15:0]               crc_next;
   logic                      is_data;
   logic                      is_fill;
   logic                      is_end;
   logic                      crc_ok;

   assign even_word = {ser_rkmsb_i, ser_rklsb_i, ser_r_i};

   // Stream shifted by one byte: old MS byte becomes the new LS byte
   assign odd_word = {ser_rklsb_i, holder_q[8], ser_r_i[7:0], holder_q[7:0]};

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
         holder_q <= 9'd0;
      else
         holder_q <= {ser_rkmsb_i, ser_r_i[15:8]};
   end

   assign word    = odd_q ? odd_word : even_word;
   assign is_data = (word[17:16] == 2'b00);
   assign is_fill = (word == W_COMMA) || (word == W_XON) || (word == W_XOFF);
   assign is_end  = (word == W_END);

   // Trailer sits in last_q once the end word has been seen
   assign crc_ok = (last_q == crc_q);

   // CRC runs one word behind, so the trailer never enters it
   crc16_d16 u_crc
   (
      .data_i (last_q),
      .crc_i  (crc_q),
      .crc_o  (crc_next)
   );

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
      begin
         state_q <= serdes_rx_pkg::rx_idle;
         odd_q   <= 1'b0;
         sop_q   <= 1'b0;
         crc_q   <= 16'hFFFF;
      end
      else
      begin
         case (state_q)
            serdes_rx_pkg::rx_idle:
            begin
               sop_q <= 1'b0;
               crc_q <= 16'hFFFF;
               if (even_word == W_START)
               begin
                  odd_q   <= 1'b0;
                  state_q <= serdes_rx_pkg::rx_first_half;
               end
               else if (odd_word == W_START)
               begin
                  odd_q   <= 1'b1;
                  state_q <= serdes_rx_pkg::rx_first_half;
               end
            end
            serdes_rx_pkg::rx_first_half:
            begin
               if (is_data)
                  state_q <= serdes_rx_pkg::rx_first_full;
               else if (!is_fill)
                  state_q <= serdes_rx_pkg::rx_error;
            end
            serdes_rx_pkg::rx_first_full:
            begin
               if (is_data)
               begin
                  crc_q   <= crc_next;
                  sop_q   <= 1'b1;       // First line now pending
                  state_q <= serdes_rx_pkg::rx_pkt_half;
               end
               else if (!is_fill)
                  state_q <= serdes_rx_pkg::rx_error;
            end
            serdes_rx_pkg::rx_pkt_half:
            begin
               if (is_data)
               begin
                  crc_q   <= crc_next;
                  state_q <= serdes_rx_pkg::rx_pkt_full;
               end
               else if (!is_fill)
                  state_q <= serdes_rx_pkg::rx_error;
            end
            serdes_rx_pkg::rx_pkt_full:
            begin
               if (is_data)
               begin
                  crc_q <= crc_next;
                  if (fifo_full_i)
                     state_q <= serdes_rx_pkg::rx_error;  // Pending line cannot go out
                  else
                  begin
                     sop_q   <= 1'b0;
                     state_q <= serdes_rx_pkg::rx_pkt_half;
                  end
               end
               else if (is_end)
                  state_q <= serdes_rx_pkg::rx_crc_check;
               else if (!is_fill)
                  state_q <= serdes_rx_pkg::rx_error;
            end
            serdes_rx_pkg::rx_crc_check:
            begin
               if (crc_ok && !fifo_full_i)
                  state_q <= serdes_rx_pkg::rx_done;
               else
                  state_q <= serdes_rx_pkg::rx_error;
            end
            serdes_rx_pkg::rx_error:
            begin
               if (!fifo_full_i)
                  state_q <= serdes_rx_pkg::rx_idle;  // Error entry goes out now
            end
            serdes_rx_pkg::rx_done:
            begin
               sop_q   <= 1'b0;
               state_q <= serdes_rx_pkg::rx_idle;
            end
            default:
               state_q <= serdes_rx_pkg::rx_idle;
         endcase
      end
   end

   // Payload registers
   always_ff @(posedge ser_rx_clk)
   begin
      if (is_data && (state_q inside {serdes_rx_pkg::rx_first_half,
                                      serdes_rx_pkg::rx_first_full,
                                      serdes_rx_pkg::rx_pkt_half,
                                      serdes_rx_pkg::rx_pkt_full}))
         last_q <= word[15:0];
      if (is_data && ((state_q == serdes_rx_pkg::rx_first_full) ||
                      ((state_q == serdes_rx_pkg::rx_pkt_full) && !fifo_full_i)))
         line_q <= {word[15:0], last_q};
   end

   // The pending line goes out when the next line completes or at the trailer
   always_comb
   begin
      entry_o.err   = 1'b0;
      entry_o.sop   = sop_q;
      entry_o.eop   = 1'b0;
      entry_o.line  = line_q;
      entry_write_o = 1'b0;
      case (state_q)
         serdes_rx_pkg::rx_pkt_full:
            entry_write_o = is_data & ~fifo_full_i;
         serdes_rx_pkg::rx_crc_check:
         begin
            entry_o.eop   = 1'b1;
            entry_write_o = crc_ok & ~fifo_full_i;
         end
         serdes_rx_pkg::rx_error:
         begin
            entry_o.err   = 1'b1;
            entry_write_o = ~fifo_full_i;
         end
         default:
            entry_write_o = 1'b0;
      endcase
   end

endmodule

//--- source/crc16_d16.sv
`timescale 1ns/1ps

module crc16_d16
(
   input  logic [15:0] data_i,
   input  logic [15:0] crc_i,
   output logic [15:0] crc_o
);

   localparam logic [15:0] POLY = 16'h1021;  // x^16 + x^12 + x^5 + 1

   logic [15:0] crc_v;
   logic        fb;

   // Sixteen serial steps unrolled into one XOR network
   // Data bit 15 enters first
   always_comb
   begin
      crc_v = crc_i;
      fb    = 1'b0;
      for (int i = 15; i >= 0; i--)
      begin
         fb    = crc_v[15] ^ data_i[i];
         crc_v = {crc_v[14:0], 1'b0} ^ ({16{fb}} & POLY);
      end
      crc_o = crc_v;
   end

endmodule

//--- source/serdes_rx_pkg.sv
package serdes_rx_pkg;

   // Deframer states
   typedef enum logic [2:0]
   {
      rx_idle,
      rx_first_half,   // Waiting for low half of first line
      rx_first_full,   // Waiting for high half of first line
      rx_pkt_half,
      rx_pkt_full,
      rx_crc_check,
      rx_error,
      rx_done
   } rx_state_t;

   // One FIFO entry, a 32-bit line plus packet flags
   typedef struct packed
   {
      logic        err;    // Packet ended in error
      logic        sop;    // First line of packet
      logic        eop;    // Last line, trailer checked
      logic [31:0] line;   // First half-word in [15:0]
   } rx_entry_t;

endpackage

//--- include/serdes_rx_config.svh
`ifndef SERDES_RX_CONFIG_SVH
`define SERDES_RX_CONFIG_SVH

// Decoded 8b/10b characters, LS byte goes out first on the line
`define SERDES_RX_K_COMMA     8'hBC  // K28.5
`define SERDES_RX_K_IDLE      8'h3C  // K28.1
`define SERDES_RX_K_PKT_START 8'hDC  // K28.6
`define SERDES_RX_K_PKT_END   8'h9C  // K28.4
`define SERDES_RX_K_XON       8'h5C  // K28.2
`define SERDES_RX_K_XOFF      8'h7C  // K28.3

// Invalid codes, reported by the deserializer itself
`define SERDES_RX_K_LOS       8'hFF  // K31.7, loss of input signal
`define SERDES_RX_K_ERROR     8'h00  // K0.0, code error

`define SERDES_RX_D_56        8'hC5  // D5.6, pairs with the comma

// Line FIFO holds 2^AWIDTH - 1 entries
`define SERDES_RX_FIFO_AWIDTH 9

`define SERDES_RX_LINK_FILTER 3      // Good samples needed for link-up

`endif
